// File: Makefile
# Verilator flow for the ARP and ICMP echo responder
TOP = eth_icmp_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

# Passes only if the testbench printed its pass message
sim:
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null

clean:
	rm -rf obj_dir

// File: build.f
common/eth_pkg.sv
common/eth_tx_if.sv
hdl/payload_fifo.sv
hdl/arp/arp_responder.sv
hdl/icmp/icmp_rx.sv
hdl/icmp/icmp_tx.sv
hdl/eth_ctrl.sv
hdl/eth_icmp_top.sv
verification/eth_icmp_checker.sv
verification/eth_icmp_tb.sv

// File: common/eth_pkg.sv
/* Ethernet, ARP, IPv4 and ICMP constants, packet type enums
   and the echo descriptor passed from icmp_rx to icmp_tx */
package eth_pkg;

  // Ethertypes --------------------
  localparam logic [15:0] ETH_TYPE_ARP  = 16'h0806;
  localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;

  // Framing --------------------
  localparam logic [7:0] ETH_PRE = 8'h55;   // Preamble byte
  localparam logic [7:0] ETH_SFD = 8'hd5;   // Start of frame delimiter
  localparam int PREAMBLE_LEN  = 8;         // Incl. SFD
  localparam int MIN_FRAME_LEN = 60;        // No FCS, zero padded
  localparam int IFG_CYCLES    = 12;

  // Header lengths in bytes
  localparam int ETH_HDR_LEN  = 14;
  localparam int ARP_LEN      = 28;
  localparam int IP_HDR_LEN   = 20;
  localparam int ICMP_HDR_LEN = 4;          // Type, code, checksum

  localparam logic [7:0] IP_VER_IHL    = 8'h45;  // IPv4, 5 words
  localparam logic [7:0] IP_PROTO_ICMP = 8'd1;

  typedef enum logic [15:0] {arp_request = 16'd1, arp_reply = 16'd2} arp_oper_e;
  typedef enum logic [7:0]  {echo_reply = 8'd0, echo_request = 8'd8} icmp_type_e;

  // Echo request fields needed for the reply
  typedef struct packed {
    logic [47:0] peer_mac;
    logic [31:0] peer_ip;
    logic [15:0] ip_id;
    logic [7:0]  ip_ttl;
    logic [15:0] ip_csum;
    logic [15:0] icmp_csum;
    logic [15:0] payload_len;               // Identifier, sequence and data
  } echo_info_t;

endpackage

// File: common/eth_tx_if.sv
/* Frame source to transmit arbiter link, four-phase req/ack
   plus the GMII byte stream of the granted frame */
interface eth_tx_if;

  logic       req;     // Frame ready
  logic       ack;     // Grant from arbiter
  logic       tx_en;   // Byte valid
  logic [7:0] txd;

  modport source (
    output req, tx_en, txd,
    input  ack
  );

  modport arbiter (
    input  req, tx_en, txd,
    output ack
  );

endinterface

// File: hdl/arp/arp_responder.sv
/* ARP request parser and ARP reply transmitter
   Answers requests for BOARD_IP, one reply in flight */
module arp_responder #(
  parameter logic [47:0] BOARD_MAC = 48'h00_11_22_33_44_55,
  parameter logic [31:0] BOARD_IP  = {8'd192, 8'd168, 8'd1, 8'd10}
) (
  input  logic       gmii_rx_clk,
  input  logic       arst_n,
  input  logic       gmii_rx_dv,
  input  logic [7:0] gmii_rxd,
  eth_tx_if.source   tx
);

  localparam int ARP_PAD  = eth_pkg::MIN_FRAME_LEN - eth_pkg::ETH_HDR_LEN - eth_pkg::ARP_LEN;
  localparam int TX_BYTES = eth_pkg::PREAMBLE_LEN + eth_pkg::MIN_FRAME_LEN;

  typedef enum logic [2:0] {st_idle, st_preamble, st_header, st_body, st_done} rx_state_e;

  rx_state_e             state;
  logic [5:0]            rx_cnt;     // Byte index after SFD
  logic [47:0]           sh;         // Previous bytes
  logic [47:0]           cur;        // Previous bytes plus current one
  logic                  ok;         // Checks passed so far
  logic                  accept;
  logic [47:0]           peer_mac;
  logic [31:0]           peer_ip;
  logic                  sending;
  logic [6:0]            tx_cnt;
  logic [TX_BYTES*8-1:0] frame;      // Shifted out MSB first
  logic [TX_BYTES*8-1:0] reply;

  assign cur = {sh[39:0], gmii_rxd};

  // Last byte of target IP, all checks done
  assign accept = (state == st_body) && gmii_rx_dv && (rx_cnt == 6'd41) && ok &&
                  (cur[31:0] == BOARD_IP);

  // Receive --------------------
  always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= st_idle;
      rx_cnt <= '0;
      ok     <= 1'b0;
    end else begin
      case (state)
        st_idle:
          if (gmii_rx_dv) begin
            // Busy with a reply, drop whole frame
            if (gmii_rxd == eth_pkg::ETH_PRE && !tx.req && !tx.ack)
              state <= st_preamble;
            else
              state <= st_done;
          end
        st_preamble: begin
          rx_cnt <= '0;
          if (!gmii_rx_dv)
            state <= st_idle;
          else if (gmii_rxd == eth_pkg::ETH_SFD)
            state <= st_header;
          else if (gmii_rxd != eth_pkg::ETH_PRE)
            state <= st_done;
        end
        st_header, st_body: begin
          rx_cnt <= rx_cnt + 6'd1;
          if (!gmii_rx_dv) begin
            state <= st_idle;                                   // Runt
          end else begin
            case (rx_cnt)
              6'd5:  ok <= (cur == BOARD_MAC) || (&cur);         // Unicast or broadcast
              6'd13: state <= (cur[15:0] == eth_pkg::ETH_TYPE_ARP) ? st_body : st_done;
              6'd21: ok <= ok && (cur[15:0] == eth_pkg::arp_request);
              6'd41: state <= st_done;
              default: ;
            endcase
          end
        end
        default:
          if (!gmii_rx_dv) state <= st_idle;                   // Wait end of frame
      endcase
    end
  end

  // Sender fields, stable while a reply is pending
  always_ff @(posedge gmii_rx_clk) begin
    if (gmii_rx_dv)
      sh <= cur;
    if (state == st_body && rx_cnt == 6'd27)
      peer_mac <= cur;
    if (state == st_body && rx_cnt == 6'd31)
      peer_ip <= cur[31:0];
  end

  // Transmit --------------------
  assign reply = {{(eth_pkg::PREAMBLE_LEN - 1){eth_pkg::ETH_PRE}}, eth_pkg::ETH_SFD,
                  peer_mac, BOARD_MAC, eth_pkg::ETH_TYPE_ARP,
                  16'h0001, eth_pkg::ETH_TYPE_IPV4, 8'd6, 8'd4,  // Ethernet, IPv4 sizes
                  eth_pkg::arp_reply, BOARD_MAC, BOARD_IP, peer_mac, peer_ip,
                  {(ARP_PAD * 8){1'b0}}};

  always_ff @(posedge gmii_rx_clk) begin
    if (sending)
      frame <= frame << 8;
    else
      frame <= reply;                                          // Loaded on grant
  end

  always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
    if (!arst_n) begin
      tx.req  <= 1'b0;
      sending <= 1'b0;
      tx_cnt  <= '0;
    end else if (sending) begin
      tx_cnt <= tx_cnt + 7'd1;
      if (tx_cnt == 7'(TX_BYTES - 1)) begin
        sending <= 1'b0;
        tx.req  <= 1'b0;                                       // Cycle after last byte
      end
    end else if (tx.req && tx.ack) begin
      sending <= 1'b1;
      tx_cnt  <= '0;
    end else if (accept) begin
      tx.req <= 1'b1;
    end
  end

  assign tx.tx_en = sending;
  assign tx.txd   = frame[TX_BYTES*8-1 -: 8];

endmodule

// File: hdl/eth_ctrl.sv
/* Transmit arbiter for the ARP and ICMP frame sources
   Alternating priority, registered GMII output, inter-frame gap */
module eth_ctrl (
  input  logic        gmii_rx_clk,
  input  logic        arst_n,
  eth_tx_if.arbiter   arp,
  eth_tx_if.arbiter   icmp,
  output logic        gmii_tx_en,
  output logic [7:0]  gmii_txd
);

  typedef enum logic [1:0] {st_idle, st_grant, st_gap} arb_state_e;

  arb_state_e                             state;
  logic                                   last_icmp;  // Last served, also current grant
  logic                                   pick_icmp;
  logic [$clog2(eth_pkg::IFG_CYCLES)-1:0] gap_cnt;

  // ICMP wins if alone or if ARP went last
  assign pick_icmp = icmp.req && (!arp.req || !last_icmp);

  assign arp.ack  = (state == st_grant) && !last_icmp;
  assign icmp.ack = (state == st_grant) && last_icmp;

  always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= st_idle;
      last_icmp  <= 1'b0;
      gap_cnt    <= '0;
      gmii_tx_en <= 1'b0;
    end else begin
      gmii_tx_en <= (state == st_grant) && (last_icmp ? icmp.tx_en : arp.tx_en);
      case (state)
        st_idle:
          if (arp.req || icmp.req) begin
            last_icmp <= pick_icmp;
            state     <= st_grant;
          end
        st_grant:
          if (!(last_icmp ? icmp.req : arp.req)) begin     // Frame done
            gap_cnt <= '0;
            state   <= st_gap;
          end
        default: begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_cnt == ($bits(gap_cnt))'(eth_pkg::IFG_CYCLES - 1))
            state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge gmii_rx_clk) begin
    gmii_txd <= last_icmp ? icmp.txd : arp.txd;
  end

endmodule

// File: hdl/eth_icmp_top.sv
/* ARP and ICMP echo responder, GMII in and out
   Responders, payload FIFO and transmit arbiter */
module eth_icmp_top #(
  parameter logic [47:0] BOARD_MAC  = 48'h00_11_22_33_44_55,
  parameter logic [31:0] BOARD_IP   = {8'd192, 8'd168, 8'd1, 8'd10},
  parameter int          FIFO_DEPTH = 2048
) (
  input  logic       gmii_rx_clk,
  input  logic       arst_n,
  input  logic       gmii_rx_dv,
  input  logic [7:0] gmii_rxd,
  output logic       gmii_tx_en,
  output logic [7:0] gmii_txd
);

  eth_tx_if arp_if ();
  eth_tx_if icmp_if ();

  eth_pkg::echo_info_t echo_info;
  logic                echo_req;
  logic                echo_ack;
  logic                fifo_wr_en;
  logic [7:0]          fifo_wr_data;
  logic                fifo_flush;
  logic                fifo_rd_en;
  logic [7:0]          fifo_rd_data;

  arp_responder #(.BOARD_MAC(BOARD_MAC), .BOARD_IP(BOARD_IP)) u_arp_responder (
    .gmii_rx_clk (gmii_rx_clk),
    .arst_n      (arst_n),
    .gmii_rx_dv  (gmii_rx_dv),
    .gmii_rxd    (gmii_rxd),
    .tx          (arp_if.source)
  );

  icmp_rx #(.BOARD_MAC(BOARD_MAC), .BOARD_IP(BOARD_IP), .FIFO_DEPTH(FIFO_DEPTH)) u_icmp_rx (
    .gmii_rx_clk  (gmii_rx_clk),
    .arst_n       (arst_n),
    .gmii_rx_dv   (gmii_rx_dv),
    .gmii_rxd     (gmii_rxd),
    .echo_ack     (echo_ack),
    .echo_req     (echo_req),
    .echo_info    (echo_info),
    .fifo_wr_en   (fifo_wr_en),
    .fifo_wr_data (fifo_wr_data),
    .fifo_flush   (fifo_flush)
  );

  payload_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_payload_fifo (
    .gmii_rx_clk (gmii_rx_clk),
    .arst_n      (arst_n),
    .wr_en       (fifo_wr_en),
    .wr_data     (fifo_wr_data),
    .rd_en       (fifo_rd_en),
    .flush       (fifo_flush),
    .rd_data     (fifo_rd_data)
  );

  icmp_tx #(.BOARD_MAC(BOARD_MAC), .BOARD_IP(BOARD_IP)) u_icmp_tx (
    .gmii_rx_clk  (gmii_rx_clk),
    .arst_n       (arst_n),
    .echo_req     (echo_req),
    .echo_info    (echo_info),
    .fifo_rd_data (fifo_rd_data),
    .echo_ack     (echo_ack),
    .fifo_rd_en   (fifo_rd_en),
    .tx           (icmp_if.source)
  );

  eth_ctrl u_eth_ctrl (
    .gmii_rx_clk (gmii_rx_clk),
    .arst_n      (arst_n),
    .arp         (arp_if.arbiter),
    .icmp        (icmp_if.arbiter),
    .gmii_tx_en  (gmii_tx_en),
    .gmii_txd    (gmii_txd)
  );

endmodule

// File: hdl/icmp/icmp_rx.sv
/* IPv4 ICMP echo request parser
   Payload into the FIFO, descriptor to icmp_tx on acceptance */
module icmp_rx #(
  parameter logic [47:0] BOARD_MAC  = 48'h00_11_22_33_44_55,
  parameter logic [31:0] BOARD_IP   = {8'd192, 8'd168, 8'd1, 8'd10},
  parameter int          FIFO_DEPTH = 2048
) (
  input  logic                gmii_rx_clk,
  input  logic                arst_n,
  input  logic                gmii_rx_dv,
  input  logic [7:0]          gmii_rxd,
  input  logic                echo_ack,
  output logic                echo_req,
  output eth_pkg::echo_info_t echo_info,
  output logic                fifo_wr_en,
  output logic [7:0]          fifo_wr_data,
  output logic                fifo_flush
);

  typedef enum logic [2:0] {st_idle, st_preamble, st_header, st_payload, st_drop} rx_state_e;

  rx_state_e   state;
  logic [15:0] cnt;      // Header index, then payload count
  logic [47:0] sh;
  logic [47:0] cur;
  logic        ok;       // Address, IHL, protocol and type checks

  assign cur          = {sh[39:0], gmii_rxd};
  assign fifo_wr_en   = (state == st_payload) && gmii_rx_dv;
  assign fifo_wr_data = gmii_rxd;

  always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= st_idle;
      cnt        <= '0;
      ok         <= 1'b0;
      echo_req   <= 1'b0;
      fifo_flush <= 1'b0;
    end else begin
      fifo_flush <= 1'b0;
      if (echo_req && echo_ack)
        echo_req <= 1'b0;
      case (state)
        st_idle:
          if (gmii_rx_dv) begin
            // One echo in flight, later requests dropped
            if (gmii_rxd == eth_pkg::ETH_PRE && !echo_req && !echo_ack)
              state <= st_preamble;
            else
              state <= st_drop;
          end
        st_preamble: begin
          cnt <= '0;
          if (!gmii_rx_dv)
            state <= st_idle;
          else if (gmii_rxd == eth_pkg::ETH_SFD)
            state <= st_header;
          else if (gmii_rxd != eth_pkg::ETH_PRE)
            state <= st_drop;
        end
        st_header: begin
          cnt <= cnt + 16'd1;
          if (!gmii_rx_dv) begin
            state <= st_idle;
          end else begin
            case (cnt)
              16'd5:  ok <= (cur == BOARD_MAC) || (&cur);
              16'd13: if (cur[15:0] != eth_pkg::ETH_TYPE_IPV4) state <= st_drop;
              16'd14: ok <= ok && (gmii_rxd == eth_pkg::IP_VER_IHL);
              16'd23: ok <= ok && (gmii_rxd == eth_pkg::IP_PROTO_ICMP);
              16'd33: ok <= ok && (cur[31:0] == BOARD_IP);
              16'd34: ok <= ok && (gmii_rxd == eth_pkg::echo_request);
              16'd37: begin
                cnt <= '0;
                // Payload must fit the FIFO
                if (echo_info.payload_len != '0 && echo_info.payload_len <= FIFO_DEPTH)
                  state <= st_payload;
                else
                  state <= st_drop;
              end
              default: ;
            endcase
          end
        end
        st_payload:
          if (!gmii_rx_dv) begin
            fifo_flush <= 1'b1;                            // Truncated frame
            state      <= st_idle;
          end else if (cnt == echo_info.payload_len - 16'd1) begin
            state <= st_drop;                              // Skip padding
            if (ok)
              echo_req <= 1'b1;
            else
              fifo_flush <= 1'b1;
          end else begin
            cnt <= cnt + 16'd1;
          end
        default:
          if (!gmii_rx_dv) state <= st_idle;
      endcase
    end
  end

  // Descriptor capture, idle while echo_req is high
  always_ff @(posedge gmii_rx_clk) begin
    if (gmii_rx_dv)
      sh <= cur;
    if (state == st_header && gmii_rx_dv) begin
      case (cnt)
        16'd11: echo_info.peer_mac <= cur;
        16'd17: echo_info.payload_len <=
                  cur[15:0] - 16'(eth_pkg::IP_HDR_LEN + eth_pkg::ICMP_HDR_LEN);
        16'd19: echo_info.ip_id <= cur[15:0];
        16'd22: echo_info.ip_ttl <= gmii_rxd;
        16'd25: echo_info.ip_csum <= cur[15:0];
        16'd29: echo_info.peer_ip <= cur[31:0];
        16'd37: echo_info.icmp_csum <= cur[15:0];
        default: ;
      endcase
    end
  end

endmodule

// File: hdl/icmp/icmp_tx.sv
/* ICMP echo reply transmitter
   Header from the descriptor, payload read back from the FIFO */
module icmp_tx #(
  parameter logic [47:0] BOARD_MAC = 48'h00_11_22_33_44_55,
  parameter logic [31:0] BOARD_IP  = {8'd192, 8'd168, 8'd1, 8'd10}
) (
  input  logic                gmii_rx_clk,
  input  logic                arst_n,
  input  logic                echo_req,
  input  eth_pkg::echo_info_t echo_info,
  input  logic [7:0]          fifo_rd_data,
  output logic                echo_ack,
  output logic                fifo_rd_en,
  eth_tx_if.source            tx
);

  localparam int HDR_BYTES = eth_pkg::PREAMBLE_LEN + eth_pkg::ETH_HDR_LEN +
                             eth_pkg::IP_HDR_LEN + eth_pkg::ICMP_HDR_LEN;
  localparam int MIN_BYTES = eth_pkg::PREAMBLE_LEN + eth_pkg::MIN_FRAME_LEN;

  typedef enum logic [2:0] {st_idle, st_grant, st_header, st_payload, st_pad, st_done}
    tx_state_e;

  tx_state_e              state;
  logic [15:0]            cnt;        // Byte index on the wire
  logic [15:0]            pay_end;    // First byte after payload
  logic [15:0]            total_len;  // IP total length
  logic [16:0]            csum_sum;
  logic [15:0]            icmp_csum;
  logic [HDR_BYTES*8-1:0] hdr;        // Zeros shift in, giving the padding
  logic [HDR_BYTES*8-1:0] hdr_init;

  assign pay_end   = 16'(HDR_BYTES) + echo_info.payload_len;
  assign total_len = 16'(eth_pkg::IP_HDR_LEN + eth_pkg::ICMP_HDR_LEN) + echo_info.payload_len;

  // Type 8 to 0 adds 0x0800 to the checksum, end-around carry
  assign csum_sum  = {1'b0, echo_info.icmp_csum} + 17'h0_0800;
  assign icmp_csum = csum_sum[15:0] + 16'(csum_sum[16]);

  // Addresses swapped, TOS and flags zero
  assign hdr_init = {{(eth_pkg::PREAMBLE_LEN - 1){eth_pkg::ETH_PRE}}, eth_pkg::ETH_SFD,
                     echo_info.peer_mac, BOARD_MAC, eth_pkg::ETH_TYPE_IPV4,
                     eth_pkg::IP_VER_IHL, 8'h00, total_len, echo_info.ip_id, 16'h0000,
                     echo_info.ip_ttl, eth_pkg::IP_PROTO_ICMP, echo_info.ip_csum,
                     BOARD_IP, echo_info.peer_ip,
                     eth_pkg::echo_reply, 8'h00, icmp_csum};

  always_ff @(posedge gmii_rx_clk) begin
    if (state == st_grant)
      hdr <= hdr_init;
    else
      hdr <= hdr << 8;
  end

  // Frame sequencer --------------------
  always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_idle;
      cnt      <= '0;
      tx.req   <= 1'b0;
      echo_ack <= 1'b0;
    end else begin
      cnt <= cnt + 16'd1;
      case (state)
        st_idle:
          if (echo_req && !tx.ack) begin                   // Previous ack seen low
            tx.req <= 1'b1;
            state  <= st_grant;
          end
        st_grant:
          if (tx.ack) begin
            cnt   <= '0;
            state <= st_header;
          end
        st_header:
          if (cnt == 16'(HDR_BYTES - 1))
            state <= st_payload;
        st_payload:
          if (cnt == pay_end - 16'd1) begin
            if (pay_end < 16'(MIN_BYTES)) begin
              state <= st_pad;
            end else begin
              tx.req   <= 1'b0;
              echo_ack <= 1'b1;
              state    <= st_done;
            end
          end
        st_pad:
          if (cnt == 16'(MIN_BYTES - 1)) begin
            tx.req   <= 1'b0;
            echo_ack <= 1'b1;                              // Whole reply sent
            state    <= st_done;
          end
        default:
          if (!echo_req) begin
            echo_ack <= 1'b0;
            state    <= st_idle;
          end
      endcase
    end
  end

  // Read one cycle ahead of the payload byte
  assign fifo_rd_en = (state == st_header && cnt == 16'(HDR_BYTES - 1)) ||
                      (state == st_payload && cnt != pay_end - 16'd1);

  assign tx.tx_en = (state == st_header) || (state == st_payload) || (state == st_pad);
  assign tx.txd   = (state == st_payload) ? fifo_rd_data : hdr[HDR_BYTES*8-1 -: 8];

endmodule

// File: hdl/payload_fifo.sv
/* Synchronous byte FIFO with registered read and flush */
module payload_fifo #(
  parameter int FIFO_DEPTH = 2048
) (
  input  logic       gmii_rx_clk,
  input  logic       arst_n,
  input  logic       wr_en,
  input  logic [7:0] wr_data,
  input  logic       rd_en,
  input  logic       flush,
  output logic [7:0] rd_data
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  logic [7:0]       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (flush) begin
      wr_ptr <= '0;                                        // Empty again
      rd_ptr <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge gmii_rx_clk) begin
    if (wr_en)
      mem[wr_ptr] <= wr_data;
    if (rd_en)
      rd_data <= mem[rd_ptr];                              // Valid next cycle
  end

endmodule

// File: verification/eth_icmp_checker.sv
/* Concurrent assertions on the transmit arbiter
   Granted sources only, granted output and minimum inter-frame gap */
module eth_icmp_checker (
  input logic clk,
  input logic arst_n,
  input logic arp_ack,
  input logic icmp_ack,
  input logic arp_tx_en,
  input logic icmp_tx_en,
  input logic gmii_tx_en
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0] low_cnt;  // Idle cycles since the last frame, saturating

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      low_cnt <= 8'hff;
    else if (gmii_tx_en)
      low_cnt <= '0;
    else if (low_cnt != 8'hff)
      low_cnt <= low_cnt + 8'd1;
  end

  // Each source drives bytes only under its own ack
  one_grant: assert property (@(posedge clk) disable iff (!arst_n)
    (!arp_tx_en || arp_ack) && (!icmp_tx_en || icmp_ack))
    else $error("Frame source driving bytes without its grant");

  // Source starts the cycle after ack, output registered once more
  tx_after_grant: assert property (@(posedge clk) disable iff (!arst_n)
    gmii_tx_en |-> $past(arp_ack || icmp_ack, 2))
    else $error("gmii_tx_en high without a grant two cycles before");

  // Gap counted before the first byte of each frame
  ifg_min: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(gmii_tx_en) |-> (int'(low_cnt) >= eth_pkg::IFG_CYCLES))
    else $error("Inter-frame gap shorter than IFG_CYCLES");

endmodule

// File: verification/eth_icmp_tb.sv
/* Testbench for the ARP and ICMP echo responder
   Stimulus table, frame builder, output collector, checks and watchdog */
module eth_icmp_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [47:0] BOARD_MAC = 48'h00_11_22_33_44_55;
  localparam logic [31:0] BOARD_IP  = {8'd192, 8'd168, 8'd1, 8'd10};
  localparam logic [47:0] PEER_MAC  = 48'h02_aa_bb_cc_dd_ee;   // Remote host
  localparam logic [31:0] PEER_IP   = {8'd192, 8'd168, 8'd1, 8'd20};
  localparam logic [47:0] BCAST     = 48'hffff_ffff_ffff;
  localparam logic [47:0] OTHER_MAC = 48'h02_00_00_00_00_01;
  localparam logic [31:0] OTHER_IP  = {8'd192, 8'd168, 8'd1, 8'd99};
  localparam logic [15:0] ARP_REQ   = 16'(eth_pkg::arp_request);
  localparam logic [15:0] ARP_REP   = 16'(eth_pkg::arp_reply);
  localparam logic [15:0] ECHO      = 16'(eth_pkg::echo_request);
  localparam int          MIN_WIRE  = eth_pkg::PREAMBLE_LEN + eth_pkg::MIN_FRAME_LEN;
  localparam int          N_TESTS   = 15;

  typedef enum {k_arp, k_icmp, k_udp} kind_e;   // UDP = IPv4 with protocol 17
  typedef struct {
    string       name;
    kind_e       kind;
    logic [47:0] mac;     // Destination
    logic [31:0] ip;
    logic [15:0] op;      // ARP opcode or ICMP type
    int          len;     // 0 picks 1..200
    bit          reply;
    bit          chain;   // Next frame follows without waiting
  } test_t;

  test_t tests [N_TESTS] = '{
    '{"arp_request",     k_arp,  BCAST,     BOARD_IP, ARP_REQ, 0,   1'b1, 1'b0},
    '{"arp_other_ip",    k_arp,  BCAST,     OTHER_IP, ARP_REQ, 0,   1'b0, 1'b0},
    '{"arp_foreign_mac", k_arp,  OTHER_MAC, BOARD_IP, ARP_REQ, 0,   1'b0, 1'b0},
    '{"arp_reply_in",    k_arp,  BCAST,     BOARD_IP, ARP_REP, 0,   1'b0, 1'b0},
    '{"echo_short",      k_icmp, BOARD_MAC, BOARD_IP, ECHO,    1,   1'b1, 1'b0},
    '{"echo_long",       k_icmp, BOARD_MAC, BOARD_IP, ECHO,    200, 1'b1, 1'b0},
    '{"echo_wrong_ip",   k_icmp, BOARD_MAC, OTHER_IP, ECHO,    0,   1'b0, 1'b0},
    '{"echo_wrong_type", k_icmp, BOARD_MAC, BOARD_IP, 16'd13,  0,   1'b0, 1'b0},
    '{"ip_wrong_proto",  k_udp,  BOARD_MAC, BOARD_IP, ECHO,    0,   1'b0, 1'b0},
    '{"echo_after_drop", k_icmp, BCAST,     BOARD_IP, ECHO,    0,   1'b1, 1'b0},
    '{"echo_with_arp",   k_icmp, BOARD_MAC, BOARD_IP, ECHO,    200, 1'b1, 1'b1},
    '{"arp_during_echo", k_arp,  BCAST,     BOARD_IP, ARP_REQ, 0,   1'b1, 1'b0},
    '{"echo_first",      k_icmp, BOARD_MAC, BOARD_IP, ECHO,    200, 1'b1, 1'b1},
    '{"echo_in_flight",  k_icmp, BOARD_MAC, BOARD_IP, ECHO,    50,  1'b0, 1'b0},
    '{"echo_later",      k_icmp, BOARD_MAC, BOARD_IP, ECHO,    0,   1'b1, 1'b0}
  };

  logic       clk;
  logic       arst_n;
  logic       gmii_rx_dv;
  logic [7:0] gmii_rxd;
  logic       gmii_tx_en;
  logic [7:0] gmii_txd;

  logic [7:0] req_q[$];      // Request frame on the wire
  logic [7:0] exp_bytes[$];  // Expected replies, back to back
  int         exp_lens[$];
  string      exp_names[$];
  logic [7:0] rx_bytes[$];   // Collected output frames
  int         rx_lens[$];
  int         cur_len  = 0;
  int         idle_cnt = 1000;
  int         errors   = 0;
  int         checks   = 0;

  eth_icmp_top #(.BOARD_MAC(BOARD_MAC), .BOARD_IP(BOARD_IP), .FIFO_DEPTH(2048)) uut (
    .gmii_rx_clk (clk),
    .arst_n      (arst_n),
    .gmii_rx_dv  (gmii_rx_dv),
    .gmii_rxd    (gmii_rxd),
    .gmii_tx_en  (gmii_tx_en),
    .gmii_txd    (gmii_txd)
  );

  bind eth_ctrl eth_icmp_checker u_checker (
    .clk        (gmii_rx_clk),
    .arst_n     (arst_n),
    .arp_ack    (arp.ack),
    .icmp_ack   (icmp.ack),
    .arp_tx_en  (arp.tx_en),
    .icmp_tx_en (icmp.tx_en),
    .gmii_tx_en (gmii_tx_en)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Output collector --------------------
  always @(negedge clk) begin
    if (gmii_tx_en) begin
      if (cur_len == 0 && idle_cnt < eth_pkg::IFG_CYCLES) begin
        errors++;
        $display("Output frame started after only %0d idle cycles", idle_cnt);
      end
      rx_bytes.push_back(gmii_txd);
      cur_len++;
      idle_cnt = 0;
    end else begin
      if (cur_len != 0)
        rx_lens.push_back(cur_len);   // Frame complete
      cur_len = 0;
      idle_cnt++;
    end
  end

  task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
  endtask

  // Ones' complement 16-bit add, end-around carry
  function automatic logic [15:0] ones_add(logic [15:0] a, logic [15:0] b);
    logic [16:0] s;
    s = {1'b0, a} + {1'b0, b};
    return s[15:0] + 16'(s[16]);
  endfunction

  task automatic add_req(logic [63:0] v, int n);
    for (int k = n - 1; k >= 0; k--)
      req_q.push_back(v[8*k +: 8]);   // MSB first
  endtask

  task automatic add_exp(logic [63:0] v, int n);
    for (int k = n - 1; k >= 0; k--)
      exp_bytes.push_back(v[8*k +: 8]);
  endtask

  // Internet checksum over n bytes of req_q, written at index at
  task automatic put_csum(int start, int n, int at);
    logic [31:0] sum;
    logic [15:0] word;
    sum = '0;
    for (int k = 0; k < n; k += 2) begin
      word = {req_q[start + k], (k + 1 < n) ? req_q[start + k + 1] : 8'h00};
      sum  = sum + 32'(word);
    end
    sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
    sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
    req_q[at]     = ~sum[15:8];
    req_q[at + 1] = ~sum[7:0];
  endtask

  // Request frame and, if answered, its expected reply
  task automatic build_request(int i);
    test_t t;
    int    plen;
    int    base;
    t    = tests[i];
    plen = (t.len == 0) ? int'($urandom_range(200, 1)) : t.len;
    req_q.delete();
    add_req(64'h5555_5555_5555_55d5, 8);
    add_req(t.mac, 6);
    add_req(PEER_MAC, 6);
    if (t.kind == k_arp) begin
      add_req(eth_pkg::ETH_TYPE_ARP, 2);
      add_req(64'h0001_0800_0604, 6);   // Ethernet, IPv4, sizes
      add_req(t.op, 2);
      add_req(PEER_MAC, 6);
      add_req(PEER_IP, 4);
      add_req(64'h0, 6);                // Target MAC unknown
      add_req(t.ip, 4);
    end else begin
      add_req(eth_pkg::ETH_TYPE_IPV4, 2);
      add_req({8'h45, 8'h00, 16'(24 + plen), 16'h1000 + 16'(i), 16'h0000}, 8);
      add_req({8'd64, (t.kind == k_udp) ? 8'd17 : 8'd1, 16'h0000}, 4);
      add_req(PEER_IP, 4);
      add_req(t.ip, 4);
      add_req({t.op[7:0], 24'h000000}, 4);
      repeat (plen) req_q.push_back(8'($urandom));
      put_csum(22, 20, 32);             // IP header
      put_csum(42, 4 + plen, 44);       // ICMP message
    end
    while (req_q.size() < MIN_WIRE)
      req_q.push_back(8'h00);
    if (!t.reply)
      return;
    base = exp_bytes.size();
    add_exp(64'h5555_5555_5555_55d5, 8);
    add_exp(PEER_MAC, 6);
    add_exp(BOARD_MAC, 6);
    if (t.kind == k_arp) begin
      add_exp(eth_pkg::ETH_TYPE_ARP, 2);
      add_exp(64'h0001_0800_0604_0002, 8);
      add_exp(BOARD_MAC, 6);
      add_exp(BOARD_IP, 4);
      add_exp(PEER_MAC, 6);
      add_exp(PEER_IP, 4);
    end else begin
      add_exp(eth_pkg::ETH_TYPE_IPV4, 2);
      for (int k = 22; k < 34; k++)
        exp_bytes.push_back(req_q[k]);  // Length, id, TTL, checksum kept
      add_exp(BOARD_IP, 4);
      add_exp(PEER_IP, 4);
      add_exp({16'h0000, ones_add({req_q[44], req_q[45]}, 16'h0800)}, 4);
      for (int k = 0; k < plen; k++)
        exp_bytes.push_back(req_q[46 + k]);
    end
    while (exp_bytes.size() - base < MIN_WIRE)
      exp_bytes.push_back(8'h00);
    exp_lens.push_back(exp_bytes.size() - base);
    exp_names.push_back(t.name);
  endtask

  task automatic drive_frame();
    foreach (req_q[k]) begin
      @(posedge clk);
      gmii_rx_dv <= 1'b1;
      gmii_rxd   <= req_q[k];
    end
    @(posedge clk);
    gmii_rx_dv <= 1'b0;
    gmii_rxd   <= 8'h00;
    repeat (eth_pkg::IFG_CYCLES) @(posedge clk);
  endtask

  // Waits for the expected replies, then matches them in order
  task automatic wait_and_compare(string name);
    int    t_wait;
    int    n_exp;
    int    n_got;
    string nm;
    t_wait = 0;
    while (rx_lens.size() < exp_lens.size() && t_wait < 1500) begin
      @(posedge clk);
      t_wait++;
    end
    repeat (300) @(posedge clk);       // Room for a late or extra frame
    while (exp_lens.size() > 0) begin
      n_exp = exp_lens.pop_front();
      nm    = exp_names.pop_front();
      if (rx_lens.size() == 0) begin
        errors++;
        $display("Reply frame for test %s never appeared on the GMII transmit port", nm);
      end else begin
        n_got = rx_lens.pop_front();
        check({nm, " length"}, n_exp, n_got);
        for (int k = 0; k < n_exp; k++) begin
          if (k < n_got)
            check($sformatf("%s byte %0d", nm, k), 32'(exp_bytes[k]), 32'(rx_bytes[k]));
        end
        repeat (n_got) void'(rx_bytes.pop_front());
      end
      repeat (n_exp) void'(exp_bytes.pop_front());
    end
    while (rx_lens.size() > 0) begin
      n_got = rx_lens.pop_front();
      errors++;
      $display("Unexpected frame of %0d bytes on the GMII transmit port after test %s",
               n_got, name);
      repeat (n_got) void'(rx_bytes.pop_front());
    end
  endtask

  // Main sequence --------------------
  initial begin
    void'($urandom(21207));
    arst_n     = 1'b0;
    gmii_rx_dv = 1'b0;
    gmii_rxd   = 8'h00;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    repeat (5) @(posedge clk);
    foreach (tests[i]) begin
      build_request(i);
      drive_frame();
      if (!tests[i].chain)
        wait_and_compare(tests[i].name);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // Watchdog, 2000 cycles per table entry
  initial begin
    repeat (N_TESTS * 2000) @(posedge clk);
    $display("Watchdog timeout: test sequence still running after %0d cycles", N_TESTS * 2000);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
